// File: Bender.yml
package:
  name: fetch_buffer

sources:
  - rtl/fetch_pkg.sv
  - rtl/fetch_buffer_ram.sv
  - rtl/fetch_prefetch.sv
  - rtl/fetch_align.sv
  - rtl/fetch_buffer_ctrl.sv
  - rtl/fetch_buffer.sv
  - target: test
    files:
      - bench/imem_model.sv
      - bench/fetch_buffer_tb.sv

// File: bench/fetch_buffer_tb.sv
`timescale 1ns/1ps

module fetch_buffer_tb import fetch_pkg::*; ();

  localparam logic [31:0] seed = 32'h5e01_3204;
  localparam int drive_delay = 10;
  localparam logic [1:0] max_latency = 2'd3;
  localparam int test_count = 5;
  localparam int test_requests = 32;
  localparam int pause_cycles = 48;
  localparam int timeout_cycles = 200 * test_count * test_requests + 4 * pause_cycles + 200;

  logic clock = 1'b0;
  logic reset;
  logic fetch_valid;
  logic [31:0] fetch_addr;
  logic fetch_spec;
  logic fetch_fence;
  logic fetch_ready;
  logic [31:0] fetch_rdata;
  logic imem_valid;
  logic [31:0] imem_addr;
  logic imem_ready;
  logic [31:0] imem_rdata;
  logic [1:0] latency = 2'd0;
  logic [31:0] lat_state = seed;
  logic [31:0] stim_state = seed;
  logic force_max = 1'b0;
  logic track = 1'b0;    // back-pressure monitor armed.
  logic draining = 1'b0; // redirect still waiting for the last request.
  logic [31:0] model_addr = 32'h0000_0000; // next word the prefetch should request.
  int model_count = 0;
  int peak_count = 0;
  int cycles = 0;
  int errors = 0;
  int requests = 0;
  int spans = 0;
  int mark = 0;

  always #50 clock = ~clock;

  fetch_buffer i_dut (.*);
  imem_model i_imem (.*);

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] random_addr();
    stim_state = lcg_step(stim_state);
    return {12'h000, stim_state[31:13], 1'b0}; // halfword aligned.
  endfunction

  function automatic logic [15:0] half_at(input logic [31:0] addr);
    logic [31:0] word;
    word = i_imem.word_at({addr[31:2], 2'b00});
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  function automatic logic [1:0] instr_step(input logic [31:0] addr);
    logic [15:0] first;
    first = half_at(addr);
    return (first[1:0] == 2'b11) ? 2'd2 : 2'd1;
  endfunction

  function automatic logic [31:0] expected_instr(input logic [31:0] addr);
    if (instr_step(addr) == 2'd1) begin
      return {16'h0000, half_at(addr)};
    end
    return {half_at(addr + 32'd2), half_at(addr)};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Mismatch %s: got %h, expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("%-26s %0d errors", name, errors - mark);
    mark = errors;
  endtask

  task automatic fetch_at(input logic [31:0] addr);
    fetch_addr  = addr;
    fetch_valid = 1'b1;
    @(negedge clock);
    while (fetch_ready !== 1'b1) begin
      @(negedge clock);
    end
    check_value("fetch_rdata", fetch_rdata, expected_instr(addr));
    requests++;
    @(posedge clock);
    #drive_delay;
    fetch_valid = 1'b0;
  endtask

  task automatic fetch_run(inout logic [31:0] addr, input int count);
    for (int i = 0; i < count; i++) begin
      if (addr[1] && (instr_step(addr) == 2'd2)) begin
        spans++; // crosses a word boundary.
      end
      fetch_at(addr);
      addr = addr + {29'd0, instr_step(addr), 1'b0};
    end
  endtask

  task automatic redirect_to(input logic [31:0] addr);
    fetch_addr = addr;
    fetch_spec = 1'b1;
    @(posedge clock);
    #drive_delay;
    fetch_spec = 1'b0;
  endtask

  // request held across the sweep must stay unanswered.
  task automatic fence_and_hold(input logic [31:0] addr);
    fetch_fence = 1'b1;
    @(posedge clock);
    #drive_delay;
    fetch_fence = 1'b0;
    fetch_addr  = addr;
    fetch_valid = 1'b1;
    repeat (fetch_depth) begin
      @(negedge clock);
      if (fetch_ready) begin
        $display("fetch_ready raised during the fence sweep at %h", addr);
        errors++;
      end
    end
    @(posedge clock);
    #drive_delay;
  endtask

  always @(negedge clock) begin
    lat_state = lcg_step(lat_state);
    latency = force_max ? max_latency : lat_state[31:30];
  end

  // a redirect resets the buffered halfword count and the next prefetch word.
  always @(negedge clock) begin
    if (!reset) begin
      model_count = 0;
      draining = 1'b0;
    end else if (fetch_spec) begin
      model_count = 0;
      model_addr = {fetch_addr[31:2], 2'b00};
      draining = 1'b1;
    end else if (draining) begin
      if (!imem_valid || imem_ready) begin
        draining = 1'b0;
      end
    end else begin
      if (track && imem_valid && (model_count > fetch_limit)) begin
        $display("imem_valid high with %0d halfwords buffered", model_count);
        errors++;
      end
      if (imem_valid && imem_ready) begin
        if (track) begin
          check_value("imem_addr", imem_addr, model_addr);
        end
        model_addr = model_addr + 32'd4;
        model_count = model_count + 2;
      end
      if (fetch_valid && fetch_ready) begin
        model_count = model_count - int'(instr_step(fetch_addr));
      end
      if (track && (model_count > peak_count)) begin
        peak_count = model_count;
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > timeout_cycles) begin
      $display("run timed out after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] start;
    logic [31:0] addr;
    reset       = 1'b0;
    fetch_valid = 1'b0;
    fetch_addr  = 32'h0000_0000;
    fetch_spec  = 1'b0;
    fetch_fence = 1'b0;
    repeat (2) @(posedge clock);
    #drive_delay;
    reset = 1'b1;

    addr = random_addr(); // first request launches prefetch.
    fetch_run(addr, test_requests);
    report_test("sequential fetch");

    addr = random_addr() | 32'd2;
    spans = 0;
    redirect_to(addr);
    fetch_run(addr, test_requests);
    if (spans == 0) begin
      $display("no instruction spanning two words was fetched");
      errors++;
    end
    report_test("compressed and misaligned");

    for (int r = 0; r < 4; r++) begin
      addr = random_addr();
      redirect_to(addr);
      fetch_run(addr, test_requests / 4);
    end
    report_test("redirect");

    for (int r = 0; r < 2; r++) begin
      start = random_addr();
      addr = start;
      redirect_to(addr);
      fetch_run(addr, test_requests / 4);
      fence_and_hold(start);
      addr = start;
      fetch_run(addr, test_requests / 4);
    end
    report_test("fence");

    force_max = 1'b1;
    track = 1'b1;
    addr = random_addr();
    redirect_to(addr);
    for (int b = 0; b < 4; b++) begin
      fetch_run(addr, test_requests / 4);
      repeat (pause_cycles) @(posedge clock);
      #drive_delay;
    end
    track = 1'b0;
    force_max = 1'b0;
    if (peak_count < fetch_limit) begin
      $display("prefetch never reached the buffer limit, peak %0d", peak_count);
      errors++;
    end
    report_test("back-pressure");

    $display("%0d requests, %0d errors", requests, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: bench/imem_model.sv
`timescale 1ns/1ps

module imem_model (
  input  logic        clock,
  input  logic        reset,
  input  logic        imem_valid,
  input  logic [31:0] imem_addr,
  input  logic [1:0]  latency,
  output logic        imem_ready,
  output logic [31:0] imem_rdata
);

  logic [1:0] wait_left; // cycles before the current request is answered.

  // hashed word content, with a few halfwords pinned so every fourth word
  // ends in a 32-bit instruction that crosses into the next word.
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [31:0] h;
    h = addr ^ 32'h9e37_79b9;
    h = h * 32'h85eb_ca6b;
    h = h ^ (h >> 13);
    h = h * 32'hc2b2_ae35;
    h = h ^ (h >> 16);
    case (addr[3:2])
      2'd0: begin
        h[17:16] = 2'b00; // upper half compressed.
      end
      2'd1: begin
        h[1:0]   = 2'b01;
        h[17:16] = 2'b11;
      end
      default: begin
      end
    endcase
    return h;
  endfunction

  assign imem_ready = imem_valid && (wait_left == 2'd0);
  assign imem_rdata = imem_ready ? word_at(imem_addr) : 32'h0000_0000;

  always_ff @(posedge clock) begin
    if (!reset) begin
      wait_left <= 2'd0;
    end else if (imem_ready) begin
      wait_left <= latency; // taken up by the next request.
    end else if (imem_valid) begin
      wait_left <= wait_left - 2'd1;
    end
  end

endmodule

// File: rtl/fetch_align.sv
`timescale 1ns/1ps

module fetch_align import fetch_pkg::*; (
  input  logic                         pending,
  input  logic [31:0]                  paddr1,
  input  logic [fetch_entry_width-1:0] rdata1,
  input  logic [fetch_entry_width-1:0] rdata2,
  input  logic [fetch_entry_width-1:0] wdata,
  input  logic                         wen,
  output logic [31:0]                  rdata,
  output logic                         hit,
  output logic [1:0]                   step
);

  logic [31:0] paddr2;
  logic [fetch_tag_width-1:0] tag1;
  logic [fetch_tag_width-1:0] tag2;
  logic [fetch_tag_width-1:0] wtag;
  logic bypass1;
  logic bypass2;
  logic have1;
  logic have2;
  logic [31:0] word1;
  logic [31:0] word2;
  logic [15:0] first;
  logic [15:0] second;
  logic compressed;
  logic found;

  assign paddr2 = paddr1 + 32'd4;
  assign tag1   = paddr1[31:2];
  assign tag2   = paddr2[31:2];
  assign wtag   = wdata[fetch_valid_bit-1 -: fetch_tag_width];

  // a word being written this cycle wins over the stored copy.
  assign bypass1 = wen && wdata[fetch_valid_bit] && (wtag == tag1);
  assign bypass2 = wen && wdata[fetch_valid_bit] && (wtag == tag2);

  assign have1 = bypass1 ||
                 (rdata1[fetch_valid_bit] &&
                  (rdata1[fetch_valid_bit-1 -: fetch_tag_width] == tag1));
  assign have2 = bypass2 ||
                 (rdata2[fetch_valid_bit] &&
                  (rdata2[fetch_valid_bit-1 -: fetch_tag_width] == tag2));

  assign word1 = bypass1 ? wdata[31:0] : rdata1[31:0];
  assign word2 = bypass2 ? wdata[31:0] : rdata2[31:0];

  always_comb begin
    if (!paddr1[1]) begin
      first  = word1[15:0];
      second = word1[31:16];
    end else begin
      first  = word1[31:16]; // may span into the next word.
      second = word2[15:0];
    end
  end

  assign compressed = (first[1:0] != 2'b11);

  always_comb begin
    if (!paddr1[1]) begin
      found = have1;
    end else begin
      found = have1 && (compressed || have2);
    end
  end

  assign hit = pending && found;

  always_comb begin
    if (compressed) begin
      rdata = {16'h0000, first};
    end else begin
      rdata = {second, first};
    end
  end

  // halfwords consumed, only when the instruction leaves.
  always_comb begin
    step = 2'd0;
    if (hit) begin
      step = compressed ? 2'd1 : 2'd2;
    end
  end

endmodule

// File: rtl/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer import fetch_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        fetch_valid,
  input  logic [31:0] fetch_addr,
  input  logic        fetch_spec,
  input  logic        fetch_fence,
  output logic        fetch_ready,
  output logic [31:0] fetch_rdata,
  output logic        imem_valid,
  output logic [31:0] imem_addr,
  input  logic        imem_ready,
  input  logic [31:0] imem_rdata
);

  logic halt;
  logic restart;
  logic [31:0] restart_addr;
  logic fill;
  logic full;
  logic [31:0] fill_addr;
  logic [1:0] step;
  logic pending;
  logic [31:0] paddr1;
  logic hit;
  logic wen;
  logic [fetch_index_width-1:0] waddr;
  logic [fetch_index_width-1:0] raddr1;
  logic [fetch_index_width-1:0] raddr2;
  logic [fetch_entry_width-1:0] wdata;
  logic [fetch_entry_width-1:0] rdata1;
  logic [fetch_entry_width-1:0] rdata2;

  fetch_buffer_ctrl i_ctrl (
    .clock        (clock),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_spec   (fetch_spec),
    .fetch_fence  (fetch_fence),
    .fetch_addr   (fetch_addr),
    .fill         (fill),
    .full         (full),
    .fill_addr    (fill_addr),
    .imem_rdata   (imem_rdata),
    .hit          (hit),
    .halt         (halt),
    .restart      (restart),
    .restart_addr (restart_addr),
    .pending      (pending),
    .paddr1       (paddr1),
    .wen          (wen),
    .waddr        (waddr),
    .raddr1       (raddr1),
    .raddr2       (raddr2),
    .wdata        (wdata),
    .fetch_ready  (fetch_ready)
  );

  fetch_prefetch i_prefetch (
    .clock        (clock),
    .reset        (reset),
    .halt         (halt),
    .restart      (restart),
    .imem_ready   (imem_ready),
    .restart_addr (restart_addr),
    .step         (step),
    .imem_valid   (imem_valid),
    .imem_addr    (imem_addr),
    .fill_addr    (fill_addr),
    .fill         (fill),
    .full         (full)
  );

  fetch_align i_align (
    .pending (pending),
    .paddr1  (paddr1),
    .rdata1  (rdata1),
    .rdata2  (rdata2),
    .wdata   (wdata),
    .wen     (wen),
    .rdata   (fetch_rdata),
    .hit     (hit),
    .step    (step)
  );

  fetch_buffer_ram i_ram (
    .clock  (clock),
    .wen    (wen),
    .waddr  (waddr),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .wdata  (wdata),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

endmodule

// File: rtl/fetch_buffer_ctrl.sv
`timescale 1ns/1ps

module fetch_buffer_ctrl import fetch_pkg::*; (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         fetch_valid,
  input  logic                         fetch_spec,
  input  logic                         fetch_fence,
  input  logic [31:0]                  fetch_addr,
  input  logic                         fill,
  input  logic                         full,
  input  logic [31:0]                  fill_addr,
  input  logic [31:0]                  imem_rdata,
  input  logic                         hit,
  output logic                         halt,
  output logic                         restart,
  output logic [31:0]                  restart_addr,
  output logic                         pending,
  output logic [31:0]                  paddr1,
  output logic                         wen,
  output logic [fetch_index_width-1:0] waddr,
  output logic [fetch_index_width-1:0] raddr1,
  output logic [fetch_index_width-1:0] raddr2,
  output logic [fetch_entry_width-1:0] wdata,
  output logic                         fetch_ready
);

  localparam logic [fetch_index_width-1:0] last_index = fetch_index_width'(fetch_depth - 1);

  fetch_state_t state;
  fetch_state_t state_next;
  logic stale;      // buffer contents unrelated to the next request.
  logic stale_next;
  logic [31:0] target;
  logic [31:0] target_next;
  logic [fetch_index_width-1:0] sweep_index;
  logic [fetch_index_width-1:0] sweep_index_next;
  logic [31:0] next_word;
  logic relaunch;

  assign halt    = (state != active) || stale;
  assign pending = fetch_valid && !halt;

  assign paddr1    = fetch_addr;
  assign next_word = fetch_addr + 32'd4;
  assign raddr1    = fetch_addr[fetch_index_width+1:2];
  assign raddr2    = next_word[fetch_index_width+1:2];

  // after a fence or reset the first request sets the prefetch target.
  assign relaunch = (state == active) && stale && fetch_valid;

  // restart only once the last memory request has drained.
  assign restart = (state == redirect) && (fill || full) && !fetch_spec && !fetch_fence;
  assign restart_addr = target;

  assign fetch_ready = hit && pending && !halt;

  always_comb begin
    wen   = 1'b0;
    waddr = fill_addr[fetch_index_width+1:2];
    wdata = '0;
    if (state == sweep) begin
      wen   = 1'b1;
      waddr = sweep_index; // zero entry.
    end else if ((state == active) && fill) begin
      wen   = 1'b1;
      wdata = {1'b1, fill_addr[31:2], imem_rdata};
    end
  end

  always_comb begin
    state_next       = state;
    stale_next       = stale;
    target_next      = target;
    sweep_index_next = sweep_index;
    case (state)
      idle: begin
        state_next = active;
      end
      active, redirect: begin
        if (fetch_fence) begin
          state_next       = sweep;
          stale_next       = 1'b1;
          sweep_index_next = '0;
        end else if (fetch_spec || relaunch) begin
          state_next  = redirect;
          target_next = fetch_addr;
        end else if (restart) begin
          state_next = active;
          stale_next = 1'b0;
        end
      end
      sweep: begin
        sweep_index_next = sweep_index + 1'b1;
        if (sweep_index == last_index) begin
          state_next = active;
        end
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state       <= idle;
      stale       <= 1'b1;
      target      <= '0;
      sweep_index <= '0;
    end else begin
      state       <= state_next;
      stale       <= stale_next;
      target      <= target_next;
      sweep_index <= sweep_index_next;
    end
  end

  // no instruction leaves while the sweep clears the buffer.
  a_sweep_quiet: assert property (
    @(posedge clock) disable iff (!reset)
    fetch_fence && ((state == active) || (state == redirect))
      |=> !fetch_ready [*fetch_depth]
  ) else $error("fetch_ready during fence sweep");

endmodule

// File: rtl/fetch_buffer_ram.sv
`timescale 1ns/1ps

module fetch_buffer_ram import fetch_pkg::*; (
  input  logic                         clock,
  input  logic                         wen,
  input  logic [fetch_index_width-1:0] waddr,
  input  logic [fetch_index_width-1:0] raddr1,
  input  logic [fetch_index_width-1:0] raddr2,
  input  logic [fetch_entry_width-1:0] wdata,
  output logic [fetch_entry_width-1:0] rdata1,
  output logic [fetch_entry_width-1:0] rdata2
);

  // all entries start out invalid.
  logic [fetch_entry_width-1:0] entries [fetch_depth] = '{default: '0};

  always_ff @(posedge clock) begin
    if (wen) begin
      entries[waddr] <= wdata;
    end
  end

  assign rdata1 = entries[raddr1]; // current word.
  assign rdata2 = entries[raddr2]; // following word.

  a_waddr_known: assert property (
    @(posedge clock) wen |-> !$isunknown(waddr)
  ) else $error("write to unknown buffer index");

endmodule

// File: rtl/fetch_pkg.sv
package fetch_pkg;

  // buffer geometry.
  localparam int fetch_depth = 8;
  localparam int fetch_index_width = $clog2(fetch_depth);

  // prefetch stops at this many buffered halfwords.
  localparam int fetch_limit = 2 * fetch_depth - 2;

  // holds fetch_limit plus one fill in flight.
  localparam int fetch_count_width = fetch_index_width + 2;

  // entry layout is {valid, tag, data}.
  localparam int fetch_tag_width = 30;
  localparam int fetch_entry_width = 1 + fetch_tag_width + 32;
  localparam int fetch_valid_bit = fetch_entry_width - 1;

  typedef enum logic [1:0] {
    idle     = 2'd0,
    active   = 2'd1,
    redirect = 2'd2,
    sweep    = 2'd3
  } fetch_state_t;

endpackage

// File: rtl/fetch_prefetch.sv
`timescale 1ns/1ps

module fetch_prefetch import fetch_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        halt,
  input  logic        restart,
  input  logic        imem_ready,
  input  logic [31:0] restart_addr,
  input  logic [1:0]  step,
  output logic        imem_valid,
  output logic [31:0] imem_addr,
  output logic [31:0] fill_addr,
  output logic        fill,
  output logic        full
);

  logic [31:0] next_addr;
  logic [fetch_count_width-1:0] count;
  logic [fetch_count_width-1:0] count_fill;
  logic [fetch_count_width-1:0] count_next;
  logic busy;

  // a request once raised is held until the memory answers, even under halt.
  assign imem_valid = busy || (!halt && (count < fetch_count_width'(fetch_limit)));
  assign imem_addr  = next_addr;
  assign fill_addr  = next_addr;
  assign fill       = imem_valid && imem_ready;

  // nothing in flight and nothing about to be issued.
  assign full = !imem_valid;

  always_comb begin
    count_fill = count;
    if (fill) begin
      count_fill = count + fetch_count_width'(2);
    end
    count_next = count_fill;
    if (fetch_count_width'(step) <= count_fill) begin
      count_next = count_fill - fetch_count_width'(step);
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      next_addr <= '0;
      count     <= '0;
      busy      <= 1'b0;
    end else if (restart) begin
      next_addr <= {restart_addr[31:2], 2'b00}; // word of the new target.
      count     <= '0;
      busy      <= 1'b0;
    end else begin
      if (fill) begin
        next_addr <= next_addr + 32'd4;
      end
      count <= count_next;
      busy  <= imem_valid && !imem_ready;
    end
  end

  a_imem_stable: assert property (
    @(posedge clock) disable iff (!reset)
    imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr)
  ) else $error("imem request changed before imem_ready");

endmodule

// File: verilog.f
rtl/fetch_pkg.sv
rtl/fetch_buffer_ram.sv
rtl/fetch_prefetch.sv
rtl/fetch_align.sv
rtl/fetch_buffer_ctrl.sv
rtl/fetch_buffer.sv
bench/imem_model.sv
bench/fetch_buffer_tb.sv
